//--- fetchStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage top: pc, instruction memory
// and hazard unit, nop insert on stall.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchStage (
   input  logic               clk,
   input  logic               rstN,
   input  logic               createDump,
   input  logic               jumpInstX,
   input  logic               branchMispredict,
   input  pipePkg::pcAddr     newPC,
   input  pipePkg::stageWrite stageD,
   input  pipePkg::stageWrite stageX,
   input  pipePkg::stageWrite stageM,
   input  pipePkg::stageWrite stageW,
   input  logic               loadEn,
   input  pipePkg::pcAddr     loadAddr,
   input  isaPkg::instrWord   loadData,
   output pipePkg::fetchOut   fetch
);

   logic             redirect;
   logic             hold;
   logic             stall;
   logic             pcErr;
   pipePkg::pcAddr   pc;
   pipePkg::pcAddr   incPC;
   isaPkg::instrWord rawInstr;
   isaPkg::instrWord instruction;
   pipePkg::fwdSel   fwdA;
   pipePkg::fwdSel   fwdB;

   assign redirect = jumpInstX | branchMispredict;
   assign hold     = stall;                        // pcUnit lets redirect win.

   pcUnit pcU (
      .clk        (clk),
      .rstN       (rstN),
      .hold       (hold),
      .createDump (createDump),
      .redirect   (redirect),
      .newPC      (newPC),
      .pc         (pc),
      .incPC      (incPC),
      .err        (pcErr)
   );

   instrMem iMem (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (pc),
      .data     (rawInstr),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData)
   );

   hazardUnit hazard (
      .instr    (rawInstr),
      .stageD   (stageD),
      .stageX   (stageX),
      .stageM   (stageM),
      .stageW   (stageW),
      .stall    (stall),
      .fwCntrlA (fwdA),
      .fwCntrlB (fwdB)
   );

   // Bubble into decode while the pc holds.
   assign instruction = (stall && !redirect) ? `FETCH_NOP : rawInstr;

   assign fetch = '{
      instruction: instruction,
      incPC:       incPC,
      fwCntrlA:    fwdA,
      fwCntrlB:    fwdB,
      err:         pcErr
   };

endmodule

//--- fetchTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage testbench: golden replay,
// then random hazards against a model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchTb;

   localparam int HALF        = 4;                 // 8 ns clock.
   localparam int RAND_CYCLES = 300;
   localparam int MARGIN      = 20;

   typedef struct packed {
      logic               dump;
      logic               jump;
      logic               misp;
      pipePkg::pcAddr     newPC;
      pipePkg::stageWrite d;
      pipePkg::stageWrite x;
      pipePkg::stageWrite m;
      pipePkg::stageWrite w;
      isaPkg::instrWord   instr;                   // Expected instruction.
      pipePkg::pcAddr     inc;                     // Expected incPC.
      logic               err;
   } goldRow;

   typedef struct packed {
      isaPkg::instrWord instr;
      pipePkg::pcAddr   inc;
      logic [4:0]       fa;
      logic [4:0]       fb;
      logic             err;
      logic             stall;
   } expView;

   logic               clk = 1'b0;
   logic               rstN = 1'b0;
   logic               createDump = 1'b0;
   logic               jumpInstX = 1'b0;
   logic               branchMispredict = 1'b0;
   pipePkg::pcAddr     newPC = '0;
   pipePkg::stageWrite stageD = '0;
   pipePkg::stageWrite stageX = '0;
   pipePkg::stageWrite stageM = '0;
   pipePkg::stageWrite stageW = '0;
   logic               loadEn = 1'b0;
   pipePkg::pcAddr     loadAddr = '0;
   isaPkg::instrWord   loadData = '0;
   pipePkg::fetchOut   fetch;

   isaPkg::instrWord memModel [`FETCH_MEM_DEPTH];   // Copy of the preload.
   pipePkg::pcAddr   preAddr [$];
   isaPkg::instrWord preData [$];
   goldRow           rows [$];
   pipePkg::pcAddr   modelPc;
   int               errors = 0;
   int               checks = 0;
   int               cycles = 0;
   int               cycleLimit = 0;
   int unsigned      lcgState = 19926;

   fetchStage dut (
      .clk              (clk),
      .rstN             (rstN),
      .createDump       (createDump),
      .jumpInstX        (jumpInstX),
      .branchMispredict (branchMispredict),
      .newPC            (newPC),
      .stageD           (stageD),
      .stageX           (stageX),
      .stageM           (stageM),
      .stageW           (stageW),
      .loadEn           (loadEn),
      .loadAddr         (loadAddr),
      .loadData         (loadData),
      .fetch            (fetch)
   );

   always #HALF clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycleLimit > 0 && cycles > cycleLimit) begin
         $display("Timeout after %0d cycles, the test did not reach its end.", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic int unsigned lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState >> 16;                      // Upper bits are less regular.
   endfunction

   task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // One-hot select of the youngest writer of src, D is bit 1.
   function automatic logic [4:0] fwdModel(input logic rd, input logic [2:0] src);
      pipePkg::stageWrite st [4];
      logic [4:0]         sel;
      st  = '{stageD, stageX, stageM, stageW};
      sel = 5'b00001;
      if (rd) begin
         for (int i = 3; i >= 0; i--) begin
            if (st[i].regWrt && st[i].wrtReg == src) begin
               sel = 5'b00010 << i;
            end
         end
      end
      return sel;
   endfunction

   function automatic expView predict();
      expView           e;
      isaPkg::instrWord raw;
      logic [4:0]       op;
      logic             rdA;
      logic             rdB;
      raw = memModel[modelPc[8:1]];
      op  = raw[15:11];
      rdA = op >= 5'b00100;
      rdB = rdA && !(op >= 5'b01000 && op <= 5'b01111);
      e.fa = fwdModel(rdA, raw[10:8]);
      e.fb = fwdModel(rdB, raw[7:5]);
      e.stall = stageD.regWrt && stageD.wbDataSel == pipePkg::wbLoad &&
                ((rdA && stageD.wrtReg == raw[10:8]) || (rdB && stageD.wrtReg == raw[7:5]));
      e.instr = (e.stall && !(jumpInstX || branchMispredict)) ? `FETCH_NOP : raw;
      e.inc = modelPc + 16'd2;
      e.err = modelPc[0] || (modelPc == 16'hFFFE);   // Odd or wraps.
      return e;
   endfunction

   // Check just before the rising edge, then advance the model pc.
   task automatic sampleCycle(input logic fromGold, input goldRow g);
      expView e;
      #(HALF - 1);
      e = predict();
      if (fromGold) begin
         e.instr = g.instr;
         e.inc   = g.inc;
         e.err   = g.err;
      end
      checkVal("fetch.instruction", fetch.instruction, e.instr);
      checkVal("fetch.incPC", fetch.incPC, e.inc);
      checkVal("fetch.fwCntrlA", 16'(fetch.fwCntrlA), 16'(e.fa));
      checkVal("fetch.fwCntrlB", 16'(fetch.fwCntrlB), 16'(e.fb));
      checkVal("fetch.err", 16'(fetch.err), 16'(e.err));
      if (jumpInstX || branchMispredict) begin
         modelPc = newPC;
      end else if (!createDump && !e.stall) begin
         modelPc = modelPc + 16'd2;
      end
      @(negedge clk);
   endtask

   function automatic int readGolden();
      int          fd;
      string       line;
      logic [15:0] v [11];
      goldRow      g;
      fd = $fopen("fetch_golden.txt", "r");
      if (fd == 0) begin
         return 0;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         if (line.getc(0) == "M" && $sscanf(line, "M %h %h", v[0], v[1]) == 2) begin
            preAddr.push_back(v[0]);
            preData.push_back(v[1]);
            memModel[v[0][8:1]] = v[1];
         end else if ($sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                              v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]) == 11) begin
            g = '{v[0][0], v[1][0], v[2][0], v[3], v[4][5:0], v[5][5:0], v[6][5:0],
                  v[7][5:0], v[8], v[9], v[10][0]};
            rows.push_back(g);
         end
      end
      $fclose(fd);
      return rows.size();
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      logic [15:0] r;
      if (readGolden() == 0) begin
         $display("Golden file fetch_golden.txt is missing or holds no cycles.");
         $display("Result: FAILED");
         $finish;
      end else begin
         cycleLimit = preAddr.size() + 5 + rows.size() + RAND_CYCLES + MARGIN;
         foreach (preAddr[i]) begin
            @(negedge clk);
            loadEn   = 1'b1;                     // Loads only land in reset.
            loadAddr = preAddr[i];
            loadData = preData[i];
         end
         @(negedge clk);
         loadEn = 1'b0;
         repeat (4) @(negedge clk);
         rstN    = 1'b1;
         modelPc = '0;
         foreach (rows[i]) begin
            createDump       = rows[i].dump;
            jumpInstX        = rows[i].jump;
            branchMispredict = rows[i].misp;
            newPC            = rows[i].newPC;
            stageD           = rows[i].d;
            stageX           = rows[i].x;
            stageM           = rows[i].m;
            stageW           = rows[i].w;
            sampleCycle(1'b1, rows[i]);
         end
         // Random hazards, pc kept inside the loaded words.
         repeat (RAND_CYCLES) begin
            r                = 16'(lcgNext());
            createDump       = (r[2:0] == 3'd0);
            jumpInstX        = (r[5:3] == 3'd0 || modelPc >= 16'd14) && r[6];
            branchMispredict = (r[5:3] == 3'd0 || modelPc >= 16'd14) && !r[6];
            newPC            = 16'(lcgNext() & 15);
            stageD           = pipePkg::stageWrite'(6'(lcgNext()));
            stageX           = pipePkg::stageWrite'(6'(lcgNext()));
            stageM           = pipePkg::stageWrite'(6'(lcgNext()));
            stageW           = pipePkg::stageWrite'(6'(lcgNext()));
            sampleCycle(1'b0, '0);
         end
         $display("Checks: %0d, errors: %0d", checks, errors);
         if (errors == 0) begin
            $display("Result: PASSED");
         end else begin
            $display("Result: FAILED");
         end
         $finish;
      end
   end

endmodule

//--- fetch_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage sizes: word and register
// widths, memory depth, no-operation word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction and byte address width.
`define FETCH_WORD_W 16

// Register index width, eight registers.
`define FETCH_REG_W 3

// Instruction memory size in words.
// The byte address is halved to index it.
`define FETCH_MEM_DEPTH 256

// No-operation word, opcode 00001 and
// all register fields zero.
`define FETCH_NOP 16'h0800

`endif

//--- fetch_golden.txt
# M lines preload memory as byte address then word, all in hex.
# C lines give dump jump mispredict newPC stageD stageX stageM stageW then instr incPC err.
M 0000 0800
M 0002 D940
M 0004 43A0
M 0006 1140
M 0008 DC80
M 000A 0800
M 000C 0800
M 000E 0800
M FFFE E000
C 0 0 0 0000 00 00 00 00 0800 0002 0
C 0 0 0 0000 25 00 00 00 0800 0004 0
C 0 0 0 0000 25 28 00 30 0800 0004 0
C 0 0 0 0000 00 24 28 00 D940 0004 0
C 0 0 0 0000 31 34 00 2C 43A0 0006 0
C 1 0 0 0000 00 00 00 00 1140 0008 0
C 1 0 0 0000 24 28 2C 30 1140 0008 0
C 0 0 0 0000 00 00 00 00 1140 0008 0
C 0 1 0 0002 31 00 00 00 DC80 000A 0
C 0 0 1 0003 00 00 00 00 D940 0004 0
C 0 1 0 FFFE 00 00 00 00 D940 0005 1
C 0 1 0 0000 00 00 00 00 E000 0000 1

//--- hazardUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit: load-use stall and operand
// forwarding selects for the fetched word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hazardUnit (
   input  isaPkg::instrWord   instr,
   input  pipePkg::stageWrite stageD,
   input  pipePkg::stageWrite stageX,
   input  pipePkg::stageWrite stageM,
   input  pipePkg::stageWrite stageW,
   output logic               stall,
   output pipePkg::fwdSel     fwCntrlA,
   output pipePkg::fwdSel     fwCntrlB
);

   localparam int REG_W = $bits(isaPkg::regIdx);

   isaPkg::opcode op;
   isaPkg::regIdx srcA;
   isaPkg::regIdx srcB;
   logic          readsA;
   logic          readsB;
   logic          isImm;
   logic          loadInD;
   logic          hitDA;
   logic          hitDB;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage will write the given register.
   function automatic logic writes(
      input pipePkg::stageWrite st,
      input isaPkg::regIdx      src
   );
      return st.regWrt && (st.wrtReg == src);
   endfunction

   // Youngest writer wins, D before X before M before W.
   function automatic pipePkg::fwdSel pickSrc(
      input logic               rd,
      input isaPkg::regIdx      src,
      input pipePkg::stageWrite d,
      input pipePkg::stageWrite x,
      input pipePkg::stageWrite m,
      input pipePkg::stageWrite w
   );
      pipePkg::fwdSel sel;
      if (!rd) begin
         sel = pipePkg::fwdNone;                   // Operand unused.
      end else if (writes(d, src)) begin
         sel = pipePkg::fwdD;
      end else if (writes(x, src)) begin
         sel = pipePkg::fwdX;
      end else if (writes(m, src)) begin
         sel = pipePkg::fwdM;
      end else if (writes(w, src)) begin
         sel = pipePkg::fwdW;
      end else begin
         sel = pipePkg::fwdNone;                   // Register file is current.
      end
      return sel;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Source decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign op   = instr[isaPkg::OPC_LSB +: isaPkg::OPC_W];
   assign srcA = instr[isaPkg::SRCA_LSB +: REG_W];
   assign srcB = instr[isaPkg::SRCB_LSB +: REG_W];

   assign readsA = (op >= isaPkg::OPC_FIRST_READER);
   assign isImm  = (op >= isaPkg::OPC_IMM_FIRST) && (op <= isaPkg::OPC_IMM_LAST);
   assign readsB = readsA & ~isImm;                // Immediates skip B.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stall and forwarding
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // A load one stage ahead has no value to forward yet.
   assign loadInD = (stageD.wbDataSel == pipePkg::wbLoad);
   assign hitDA   = readsA & writes(stageD, srcA);
   assign hitDB   = readsB & writes(stageD, srcB);
   assign stall   = loadInD & (hitDA | hitDB);

   assign fwCntrlA = pickSrc(readsA, srcA, stageD, stageX, stageM, stageW);
   assign fwCntrlB = pickSrc(readsB, srcB, stageD, stageX, stageM, stageW);

endmodule

//--- instrMem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-addressed instruction memory,
// async read, clocked program load.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fetch_defines.svh"

module instrMem (
   input  logic             clk,
   input  logic             rstN,
   input  pipePkg::pcAddr   addr,      // Byte address from pc.
   output isaPkg::instrWord data,
   input  logic             loadEn,
   input  pipePkg::pcAddr   loadAddr,  // Byte address of load.
   input  isaPkg::instrWord loadData
);

   localparam int IDX_W = $clog2(`FETCH_MEM_DEPTH);

   typedef logic [IDX_W-1:0] wordIdx;

   isaPkg::instrWord mem [`FETCH_MEM_DEPTH];
   wordIdx           rdIdx;
   wordIdx           wrIdx;

   // Bit 0 dropped, upper bits wrap.
   assign rdIdx = addr[IDX_W:1];
   assign wrIdx = loadAddr[IDX_W:1];

   assign data = mem[rdIdx];                       // Same-cycle read.

   // Program load is accepted only while the core is held in reset,
   // so a running program cannot overwrite itself.
   always_ff @(posedge clk) begin
      if (loadEn && !rstN) begin
         mem[wrIdx] <= loadData;
      end
   end

endmodule

//--- isaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set view used by fetch:
// word types, field positions, classes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fetch_defines.svh"

package isaPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Basic types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int OPC_W = 5;                      // Opcode field width.

   typedef logic [`FETCH_WORD_W-1:0] instrWord;   // Full instruction.
   typedef logic [`FETCH_REG_W-1:0]  regIdx;      // Register number.
   typedef logic [OPC_W-1:0]         opcode;      // Major opcode.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Field positions
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int OPC_LSB  = 11;                  // Bits 15..11.
   localparam int SRCA_LSB = 8;                   // Bits 10..8.
   localparam int SRCB_LSB = 5;                   // Bits 7..5.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcode classes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Halt, nop, jump and jump-and-link sit below this value
   // and read no registers.
   localparam opcode OPC_FIRST_READER = 5'b00100;

   // Immediate forms read source A only.
   localparam opcode OPC_IMM_FIRST = 5'b01000;    // First immediate form.
   localparam opcode OPC_IMM_LAST  = 5'b01111;    // Last immediate form.

endpackage

//--- pcUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter with +2 incrementer,
// redirect select and address error.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pcUnit (
   input  logic           clk,
   input  logic           rstN,
   input  logic           hold,        // Stall from hazard unit.
   input  logic           createDump,
   input  logic           redirect,    // Jump or mispredict.
   input  pipePkg::pcAddr newPC,
   output pipePkg::pcAddr pc,
   output pipePkg::pcAddr incPC,
   output logic           err
);

   localparam int SUM_W = `FETCH_WORD_W + 1;

   logic [SUM_W-1:0] sum;                          // Carry in the top bit.
   logic             advance;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Incrementer and error
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign sum   = {1'b0, pc} + SUM_W'(2);
   assign incPC = sum[`FETCH_WORD_W-1:0];

   // Fetch past 0xFFFE or from an odd address.
   assign err = sum[`FETCH_WORD_W] | pc[0];

   assign advance = ~createDump & ~hold;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // PC register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // A redirect wins over both a stall and a dump freeze.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= newPC;                              // Branch target.
      end else if (advance) begin
         pc <= incPC;                              // Sequential fetch.
      end
   end

endmodule

//--- pipePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline types: downstream write info,
// forwarding selects, fetch output bundle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fetch_defines.svh"

package pipePkg;

   typedef logic [`FETCH_WORD_W-1:0] pcAddr;      // Byte address.

   // Source of a stage's writeback value.
   typedef enum logic [1:0] {
      wbAlu  = 2'd0,
      wbLoad = 2'd1,                              // Known only after memory.
      wbPc   = 2'd2,
      wbImm  = 2'd3
   } wbSel;

   // What one later stage will write back.
   typedef struct packed {
      logic          regWrt;                      // Stage writes a register.
      isaPkg::regIdx wrtReg;                      // Destination register.
      wbSel          wbDataSel;                   // Where the value comes from.
   } stageWrite;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Forwarding and output
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [4:0] {
      fwdNone = 5'b00001,                         // Use register file.
      fwdD    = 5'b00010,
      fwdX    = 5'b00100,
      fwdM    = 5'b01000,
      fwdW    = 5'b10000
   } fwdSel;

   typedef struct packed {
      isaPkg::instrWord instruction;              // Fetched word or nop.
      pcAddr            incPC;                    // pc plus 2.
      fwdSel            fwCntrlA;
      fwdSel            fwCntrlB;
      logic             err;                      // Odd pc or wrap.
   } fetchOut;

endpackage

//--- src.f
+incdir+.
isaPkg.sv
pipePkg.sv
pcUnit.sv
instrMem.sv
hazardUnit.sv
fetchStage.sv
fetchTb.sv
